// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the execute stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --top-module execute_tb -Wno-fatal -f verilog.f \
  --Mdir "$build_dir" -o execute_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/execute_tb" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "sim passed" "$log"; then
  exit 0
fi
echo "Pass message not found in $log"
exit 1

// File: source/agu.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module agu (
  agu_if.unit bus
);

  logic [`XLEN-1:0] sum_base;
  logic [`XLEN-1:0] sum_pc;
  logic [1:0] offset;
  logic is_mem;
  logic is_jump;

  always_comb begin
    sum_base = bus.base + bus.imm;
    sum_pc = bus.pc + bus.imm;
    is_mem = (bus.op == exec_pkg::OP_LOAD) || (bus.op == exec_pkg::OP_STORE);
    is_jump = (bus.op == exec_pkg::OP_JAL) || (bus.op == exec_pkg::OP_JALR) ||
              (bus.op == exec_pkg::OP_BRANCH);

    bus.address = (bus.op == exec_pkg::OP_AUIPC) ? sum_pc : sum_base;
    bus.target = (bus.op == exec_pkg::OP_JALR) ? {sum_base[`XLEN-1:1], 1'b0} : sum_pc;
    offset = bus.address[1:0];

    bus.byteenable = 4'b0000;
    bus.misaligned = 1'b0;
    if (is_mem) begin
      case (bus.lsu_op)
        exec_pkg::LB, exec_pkg::LBU, exec_pkg::SB: bus.byteenable = 4'b0001 << offset;
        exec_pkg::LH, exec_pkg::LHU, exec_pkg::SH: begin
          bus.byteenable = 4'b0011 << offset;
          bus.misaligned = offset[0];
        end
        default: begin
          bus.byteenable = 4'b1111;
          bus.misaligned = offset != 2'b00;
        end
      endcase
    end else if (is_jump) begin
      bus.misaligned = bus.target[1]; // No compressed instructions.
    end

    if (!bus.misaligned) bus.ecause = exec_pkg::EC_NONE;
    else if (bus.op == exec_pkg::OP_LOAD) bus.ecause = exec_pkg::EC_LOAD_MISALIGNED;
    else if (bus.op == exec_pkg::OP_STORE) bus.ecause = exec_pkg::EC_STORE_MISALIGNED;
    else bus.ecause = exec_pkg::EC_INSTR_MISALIGNED;
  end

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module alu (
  alu_if.unit bus
);

  localparam int SHW = $clog2(`XLEN);

  logic [`XLEN-1:0] op_b;
  logic [SHW-1:0] shamt;

  always_comb begin
    op_b = bus.use_imm ? bus.imm : bus.rdata2;
    shamt = op_b[SHW-1:0];

    case (bus.alu_op)
      exec_pkg::ADD:  bus.result = bus.rdata1 + op_b;
      exec_pkg::SUB:  bus.result = bus.rdata1 - op_b;
      exec_pkg::SLL:  bus.result = bus.rdata1 << shamt;
      exec_pkg::SLT:  bus.result = {{(`XLEN-1){1'b0}}, $signed(bus.rdata1) < $signed(op_b)};
      exec_pkg::SLTU: bus.result = {{(`XLEN-1){1'b0}}, bus.rdata1 < op_b};
      exec_pkg::XOR:  bus.result = bus.rdata1 ^ op_b;
      exec_pkg::SRL:  bus.result = bus.rdata1 >> shamt;
      exec_pkg::SRA:  bus.result = $signed(bus.rdata1) >>> shamt;
      exec_pkg::OR:   bus.result = bus.rdata1 | op_b;
      exec_pkg::AND:  bus.result = bus.rdata1 & op_b;
      default:        bus.result = '0;
    endcase
  end

  // Branch compare always uses both registers.
  always_comb begin
    case (bus.branch_op)
      exec_pkg::BEQ:  bus.taken = bus.rdata1 == bus.rdata2;
      exec_pkg::BNE:  bus.taken = bus.rdata1 != bus.rdata2;
      exec_pkg::BLT:  bus.taken = $signed(bus.rdata1) < $signed(bus.rdata2);
      exec_pkg::BGE:  bus.taken = $signed(bus.rdata1) >= $signed(bus.rdata2);
      exec_pkg::BLTU: bus.taken = bus.rdata1 < bus.rdata2;
      exec_pkg::BGEU: bus.taken = bus.rdata1 >= bus.rdata2;
      default:        bus.taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/divider.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module divider (
  input logic clock,
  input logic reset,
  div_if.unit bus
);

  localparam int CW = $clog2(`DIV_STEPS);

  typedef enum logic [1:0] {IDLE, RUN, DONE} state_t;

  state_t state;
  logic [CW-1:0] count;
  logic [`XLEN-1:0] quo;
  logic [`XLEN-1:0] rem;
  logic [`XLEN-1:0] dvs;
  logic neg_quo;
  logic neg_rem;
  logic rem_sel;
  logic div_zero;
  logic signed_op;
  logic neg_a;
  logic neg_b;
  logic [`XLEN:0] partial;
  logic [`XLEN:0] diff;
  logic [`XLEN-1:0] quo_out;
  logic [`XLEN-1:0] rem_out;

  always_comb begin
    signed_op = (bus.div_op == exec_pkg::DIV) || (bus.div_op == exec_pkg::REM);
    neg_a = signed_op & bus.rdata1[`XLEN-1];
    neg_b = signed_op & bus.rdata2[`XLEN-1];
    partial = {rem, quo[`XLEN-1]}; // Shift next dividend bit in.
    diff = partial - {1'b0, dvs};
  end

  // A new start restarts the unit from any state.
  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= IDLE;
      count <= '0;
    end else if (bus.start) begin
      state <= RUN;
      count <= '0;
    end else begin
      case (state)
        RUN: begin
          count <= count + 1'b1;
          if (count == CW'(`DIV_STEPS - 1)) state <= DONE;
        end
        DONE: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (bus.start) begin
      quo <= neg_a ? -bus.rdata1 : bus.rdata1;
      dvs <= neg_b ? -bus.rdata2 : bus.rdata2;
      rem <= '0;
      neg_quo <= neg_a ^ neg_b;
      neg_rem <= neg_a; // Remainder takes the dividend sign.
      rem_sel <= (bus.div_op == exec_pkg::REM) || (bus.div_op == exec_pkg::REMU);
      div_zero <= bus.rdata2 == '0;
    end else if (state == RUN) begin
      if (!diff[`XLEN]) begin
        rem <= diff[`XLEN-1:0];
        quo <= {quo[`XLEN-2:0], 1'b1};
      end else begin
        rem <= partial[`XLEN-1:0];
        quo <= {quo[`XLEN-2:0], 1'b0};
      end
    end
  end

  // Signed overflow needs no special case. The magnitude quotient is already the dividend.
  always_comb begin
    quo_out = div_zero ? '1 : (neg_quo ? -quo : quo);
    rem_out = neg_rem ? -rem : rem;
    bus.result = rem_sel ? rem_out : quo_out;
    bus.ready = state == DONE;
  end

endmodule

`default_nettype wire

// File: source/exec_ifs.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

interface alu_if;
  logic [`XLEN-1:0] rdata1;
  logic [`XLEN-1:0] rdata2;
  logic [`XLEN-1:0] imm;
  logic use_imm;
  exec_pkg::alu_op_t alu_op;
  exec_pkg::branch_op_t branch_op;
  logic [`XLEN-1:0] result;
  logic taken;

  modport ctrl (output rdata1, rdata2, imm, use_imm, alu_op, branch_op, input result, taken);
  modport unit (input rdata1, rdata2, imm, use_imm, alu_op, branch_op, output result, taken);
endinterface

interface agu_if;
  logic [`XLEN-1:0] base;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] imm;
  exec_pkg::exec_op_t op;
  exec_pkg::lsu_op_t lsu_op;
  logic [`XLEN-1:0] address;
  logic [`XLEN-1:0] target;
  logic [3:0] byteenable;
  logic misaligned;
  exec_pkg::ecause_t ecause;

  modport ctrl (output base, pc, imm, op, lsu_op,
                input address, target, byteenable, misaligned, ecause);
  modport unit (input base, pc, imm, op, lsu_op,
                output address, target, byteenable, misaligned, ecause);
endinterface

interface div_if;
  logic start; // One-cycle pulse.
  logic [`XLEN-1:0] rdata1;
  logic [`XLEN-1:0] rdata2;
  exec_pkg::div_op_t div_op;
  logic [`XLEN-1:0] result;
  logic ready;

  modport ctrl (output start, rdata1, rdata2, div_op, input result, ready);
  modport unit (input start, rdata1, rdata2, div_op, output result, ready);
endinterface

`default_nettype wire

// File: source/exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Data and address width.
`define XLEN 32

// Register file address width.
`define REG_AW 5

// One quotient bit per iteration.
`define DIV_STEPS `XLEN

`endif

// File: source/exec_pkg.sv
`default_nettype none

package exec_pkg;

  // Instruction class from decode.
  typedef enum logic [3:0] {
    OP_NOP,
    OP_ALU,
    OP_LUI,
    OP_AUIPC,
    OP_JAL,
    OP_JALR,
    OP_BRANCH,
    OP_LOAD,
    OP_STORE,
    OP_DIV
  } exec_op_t;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND
  } alu_op_t;

  typedef enum logic [2:0] {
    BEQ,
    BNE,
    BLT,
    BGE,
    BLTU,
    BGEU
  } branch_op_t;

  typedef enum logic [2:0] {
    LB,
    LH,
    LW,
    LBU,
    LHU,
    SB,
    SH,
    SW
  } lsu_op_t;

  typedef enum logic [1:0] {
    DIV,
    DIVU,
    REM,
    REMU
  } div_op_t;

  // RISC-V mcause codes. No-exception and instruction misaligned share code 0,
  // so these are named constants rather than enum members.
  typedef logic [3:0] ecause_t;

  localparam ecause_t EC_NONE             = 4'd0;
  localparam ecause_t EC_INSTR_MISALIGNED = 4'd0;
  localparam ecause_t EC_LOAD_MISALIGNED  = 4'd4;
  localparam ecause_t EC_STORE_MISALIGNED = 4'd6;

endpackage

`default_nettype wire

// File: source/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module execute_stage (
  input logic clock,
  input logic reset,
  input logic valid,
  input exec_pkg::exec_op_t op,
  input exec_pkg::alu_op_t alu_op,
  input exec_pkg::branch_op_t branch_op,
  input exec_pkg::lsu_op_t lsu_op,
  input exec_pkg::div_op_t div_op,
  input logic use_imm,
  input logic [`XLEN-1:0] pc,
  input logic [`XLEN-1:0] imm,
  input logic [`REG_AW-1:0] raddr1,
  input logic [`REG_AW-1:0] raddr2,
  input logic [`REG_AW-1:0] waddr,
  input logic [`XLEN-1:0] rdata1,
  input logic [`XLEN-1:0] rdata2,
  input logic mem_stall,
  input logic clear,
  alu_if.ctrl alu,
  agu_if.ctrl agu,
  div_if.ctrl div,
  output logic out_valid,
  output exec_pkg::exec_op_t out_op,
  output logic [`REG_AW-1:0] out_waddr,
  output logic out_wren,
  output logic [`XLEN-1:0] out_wdata,
  output logic [`XLEN-1:0] out_address,
  output logic [3:0] out_byteenable,
  output logic [`XLEN-1:0] out_sdata,
  output logic exception,
  output exec_pkg::ecause_t ecause,
  output logic redirect,
  output logic [`XLEN-1:0] redirect_pc,
  output logic stall
);

  logic fwd_ok;
  logic [`XLEN-1:0] op1;
  logic [`XLEN-1:0] op2;
  logic div_instr;
  logic div_busy;
  logic div_done;
  logic div_ok;
  logic is_jump;
  logic is_branch;
  logic writes;
  logic accept;
  logic n_exc;
  logic n_wren;
  logic n_redirect;
  logic [`XLEN-1:0] n_wdata;
  logic [3:0] n_be;
  exec_pkg::ecause_t n_ecause;

  // Bypass from our own output register.
  always_comb begin
    fwd_ok = out_valid && out_wren && (out_waddr != '0);
    op1 = (fwd_ok && (raddr1 == out_waddr)) ? out_wdata : rdata1;
    op2 = (fwd_ok && (raddr2 == out_waddr)) ? out_wdata : rdata2;
  end

  assign alu.rdata1 = op1;
  assign alu.rdata2 = op2;
  assign alu.imm = imm;
  assign alu.use_imm = use_imm;
  assign alu.alu_op = alu_op;
  assign alu.branch_op = branch_op;

  assign agu.base = op1;
  assign agu.pc = pc;
  assign agu.imm = imm;
  assign agu.op = op;
  assign agu.lsu_op = lsu_op;

  // Ready only counts for a division we started.
  assign div_instr = valid && (op == exec_pkg::OP_DIV);
  assign div_ok = div.ready && div_busy;
  assign div.start = div_instr && !div_busy && !div_done && !clear;
  assign div.rdata1 = op1;
  assign div.rdata2 = op2;
  assign div.div_op = div_op;

  assign stall = div_instr && !(div_ok || div_done);
  assign accept = !stall && !mem_stall;

  always_comb begin
    is_jump = (op == exec_pkg::OP_JAL) || (op == exec_pkg::OP_JALR);
    is_branch = op == exec_pkg::OP_BRANCH;
    writes = (op == exec_pkg::OP_ALU) || (op == exec_pkg::OP_LUI) ||
             (op == exec_pkg::OP_AUIPC) || is_jump ||
             (op == exec_pkg::OP_LOAD) || (op == exec_pkg::OP_DIV);

    n_exc = agu.misaligned && (!is_branch || alu.taken); // Untaken branch cannot fault.
    n_wren = writes && !n_exc;
    n_redirect = (is_jump || (is_branch && alu.taken)) && !n_exc;
    n_ecause = n_exc ? agu.ecause : exec_pkg::EC_NONE;
    n_be = n_exc ? 4'b0000 : agu.byteenable;

    case (op)
      exec_pkg::OP_ALU:   n_wdata = alu.result;
      exec_pkg::OP_LUI:   n_wdata = imm;
      exec_pkg::OP_AUIPC: n_wdata = agu.address;
      exec_pkg::OP_JAL,
      exec_pkg::OP_JALR:  n_wdata = pc + `XLEN'(4);
      exec_pkg::OP_DIV:   n_wdata = div.result;
      default:            n_wdata = '0; // Load data comes from memory later.
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      out_valid <= 1'b0;
      out_wren <= 1'b0;
      exception <= 1'b0;
      redirect <= 1'b0;
    end else if (accept) begin
      out_valid <= valid;
      out_wren <= valid && n_wren;
      exception <= valid && n_exc;
      redirect <= valid && n_redirect;
    end
  end

  // Division bookkeeping. The divider holds a result that arrived under mem_stall.
  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      div_busy <= 1'b0;
      div_done <= 1'b0;
    end else begin
      if (div.start) div_busy <= 1'b1;
      else if (div_ok) div_busy <= 1'b0;
      if (div_ok && mem_stall) div_done <= 1'b1;
      else if (accept) div_done <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      out_op <= op;
      out_waddr <= waddr;
      out_wdata <= n_wdata;
      out_address <= agu.address;
      out_byteenable <= n_be;
      out_sdata <= op2;
      ecause <= n_ecause;
      redirect_pc <= agu.target;
    end
  end

endmodule

`default_nettype wire

// File: source/execute_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module execute_top (
  input logic clock,
  input logic reset,
  input logic valid,
  input exec_pkg::exec_op_t op,
  input exec_pkg::alu_op_t alu_op,
  input exec_pkg::branch_op_t branch_op,
  input exec_pkg::lsu_op_t lsu_op,
  input exec_pkg::div_op_t div_op,
  input logic use_imm,
  input logic [`XLEN-1:0] pc,
  input logic [`XLEN-1:0] imm,
  input logic [`REG_AW-1:0] raddr1,
  input logic [`REG_AW-1:0] raddr2,
  input logic [`REG_AW-1:0] waddr,
  input logic [`XLEN-1:0] rdata1,
  input logic [`XLEN-1:0] rdata2,
  input logic mem_stall,
  input logic clear,
  output logic out_valid,
  output exec_pkg::exec_op_t out_op,
  output logic [`REG_AW-1:0] out_waddr,
  output logic out_wren,
  output logic [`XLEN-1:0] out_wdata,
  output logic [`XLEN-1:0] out_address,
  output logic [3:0] out_byteenable,
  output logic [`XLEN-1:0] out_sdata,
  output logic exception,
  output exec_pkg::ecause_t ecause,
  output logic redirect,
  output logic [`XLEN-1:0] redirect_pc,
  output logic stall
);

  alu_if alu_bus ();
  agu_if agu_bus ();
  div_if div_bus ();

  execute_stage u_stage (
    .clock, .reset, .valid, .op, .alu_op, .branch_op, .lsu_op, .div_op,
    .use_imm, .pc, .imm, .raddr1, .raddr2, .waddr, .rdata1, .rdata2,
    .mem_stall, .clear,
    .alu (alu_bus.ctrl),
    .agu (agu_bus.ctrl),
    .div (div_bus.ctrl),
    .out_valid, .out_op, .out_waddr, .out_wren, .out_wdata, .out_address,
    .out_byteenable, .out_sdata, .exception, .ecause, .redirect, .redirect_pc,
    .stall
  );

  alu u_alu (.bus (alu_bus.unit));

  agu u_agu (.bus (agu_bus.unit));

  divider u_div (
    .clock,
    .reset,
    .bus (div_bus.unit)
  );

endmodule

`default_nettype wire

// File: tests/execute_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module execute_tb;

  localparam int NUM = 25;
  localparam int LIMIT = NUM * (`DIV_STEPS + 4) + 50;

  typedef struct packed {
    exec_pkg::exec_op_t op;
    exec_pkg::alu_op_t alu_op;
    exec_pkg::branch_op_t branch_op;
    exec_pkg::lsu_op_t lsu_op;
    exec_pkg::div_op_t div_op;
    logic use_imm;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] imm;
    logic [`REG_AW-1:0] raddr1;
    logic [`REG_AW-1:0] raddr2;
    logic [`REG_AW-1:0] waddr;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
    logic mem_stall;
    logic clear;
    logic [`XLEN-1:0] exp_wdata;
    logic exp_wren;
    logic [`XLEN-1:0] exp_address;
    logic [3:0] exp_be;
    logic exp_exc;
    exec_pkg::ecause_t exp_cause;
    logic exp_redirect;
    logic [`XLEN-1:0] exp_rpc;
  } entry_t;

  logic clock;
  logic reset;
  logic valid;
  exec_pkg::exec_op_t op;
  exec_pkg::alu_op_t alu_op;
  exec_pkg::branch_op_t branch_op;
  exec_pkg::lsu_op_t lsu_op;
  exec_pkg::div_op_t div_op;
  logic use_imm;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] imm;
  logic [`REG_AW-1:0] raddr1;
  logic [`REG_AW-1:0] raddr2;
  logic [`REG_AW-1:0] waddr;
  logic [`XLEN-1:0] rdata1;
  logic [`XLEN-1:0] rdata2;
  logic mem_stall;
  logic clear;
  logic out_valid;
  exec_pkg::exec_op_t out_op;
  logic [`REG_AW-1:0] out_waddr;
  logic out_wren;
  logic [`XLEN-1:0] out_wdata;
  logic [`XLEN-1:0] out_address;
  logic [3:0] out_byteenable;
  logic [`XLEN-1:0] out_sdata;
  logic exception;
  exec_pkg::ecause_t ecause;
  logic redirect;
  logic [`XLEN-1:0] redirect_pc;
  logic stall;

  entry_t tbl [NUM];
  string names [NUM];
  logic [`XLEN-1:0] stall_seen [NUM];
  logic [`XLEN-1:0] stall_cycles;
  int n;
  int cur;
  int prev;
  int held;
  int cycles = 0;
  logic pending;
  logic go;

  execute_top u_execute_top (.*);

  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles > LIMIT) begin
      $display("Timeout: tests did not finish within %0d cycles", LIMIT);
      $display("sim failed");
      $fatal(1, "Run aborted");
    end
  end

  task automatic check_data(input string test, input string what,
                            input logic [`XLEN-1:0] expected, input logic [`XLEN-1:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s %s: expected %h, actual %h", test, what, expected, actual);
      $display("sim failed");
      $fatal(1, "Stopping at first error");
    end
  endtask

  task automatic check_bit(input string test, input string what,
                           input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERROR %s %s: expected %b, actual %b", test, what, expected, actual);
      $display("sim failed");
      $fatal(1, "Stopping at first error");
    end
  endtask

  task automatic check_cause(input string test, input string what,
                             input exec_pkg::ecause_t expected, input exec_pkg::ecause_t actual);
    if (actual !== expected) begin
      $display("ERROR %s %s: expected %0d, actual %0d", test, what, expected, actual);
      $display("sim failed");
      $fatal(1, "Stopping at first error");
    end
  endtask

  task automatic check_be(input string test, input string what,
                          input logic [3:0] expected, input logic [3:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s %s: expected %b, actual %b", test, what, expected, actual);
      $display("sim failed");
      $fatal(1, "Stopping at first error");
    end
  endtask

  task automatic check_op(input string test, input string what,
                          input exec_pkg::exec_op_t expected, input exec_pkg::exec_op_t actual);
    if (actual !== expected) begin
      $display("ERROR %s %s: expected %0d, actual %0d", test, what, expected, actual);
      $display("sim failed");
      $fatal(1, "Stopping at first error");
    end
  endtask

  task automatic check_waddr(input string test, input string what,
                             input logic [`REG_AW-1:0] expected,
                             input logic [`REG_AW-1:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s %s: expected %0d, actual %0d", test, what, expected, actual);
      $display("sim failed");
      $fatal(1, "Stopping at first error");
    end
  endtask

  // Fills the decode side of entry n with the common defaults.
  task automatic set_stimulus(input string name, input exec_pkg::exec_op_t cls,
                              input logic with_imm, input logic [`XLEN-1:0] at_pc,
                              input logic [`XLEN-1:0] immediate, input logic [`REG_AW-1:0] src1,
                              input logic [`REG_AW-1:0] src2, input logic [`REG_AW-1:0] dst,
                              input logic [`XLEN-1:0] val1, input logic [`XLEN-1:0] val2);
    tbl[n] = '0;
    names[n] = name;
    tbl[n].op = cls;
    tbl[n].alu_op = exec_pkg::ADD;
    tbl[n].branch_op = exec_pkg::BEQ;
    tbl[n].lsu_op = exec_pkg::LW;
    tbl[n].div_op = exec_pkg::DIV;
    tbl[n].use_imm = with_imm;
    tbl[n].pc = at_pc;
    tbl[n].imm = immediate;
    tbl[n].raddr1 = src1;
    tbl[n].raddr2 = src2;
    tbl[n].waddr = dst;
    tbl[n].rdata1 = val1;
    tbl[n].rdata2 = val2;
  endtask

  task automatic set_expected(input logic [`XLEN-1:0] wdata, input logic wren,
                              input logic [`XLEN-1:0] address, input logic [3:0] be,
                              input logic exc, input exec_pkg::ecause_t cause,
                              input logic redir, input logic [`XLEN-1:0] rpc);
    tbl[n].exp_wdata = wdata;
    tbl[n].exp_wren = wren;
    tbl[n].exp_address = address;
    tbl[n].exp_be = be;
    tbl[n].exp_exc = exc;
    tbl[n].exp_cause = cause;
    tbl[n].exp_redirect = redir;
    tbl[n].exp_rpc = rpc;
    n = n + 1;
  endtask

  task automatic build_table();
    n = 0;
    set_stimulus("add", exec_pkg::OP_ALU, 1'b0, '0, '0, 5'd1, 5'd2, 5'd3, 32'd100, 32'd23);
    set_expected(32'd123, 1'b1, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b0, '0);
    set_stimulus("sub", exec_pkg::OP_ALU, 1'b0, '0, '0, 5'd4, 5'd5, 5'd6, 32'd5, 32'd12);
    tbl[n].alu_op = exec_pkg::SUB;
    set_expected(32'hffff_fff9, 1'b1, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b0, '0);
    set_stimulus("slt_imm", exec_pkg::OP_ALU, 1'b1, '0, 32'd5,
                 5'd7, 5'd0, 5'd8, 32'hffff_fff0, '0);
    tbl[n].alu_op = exec_pkg::SLT; // -16 < 5.
    set_expected(32'd1, 1'b1, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b0, '0);
    set_stimulus("sltu", exec_pkg::OP_ALU, 1'b0, '0, '0,
                 5'd9, 5'd10, 5'd11, 32'hffff_fff0, 32'd5);
    tbl[n].alu_op = exec_pkg::SLTU;
    set_expected(32'd0, 1'b1, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b0, '0);
    set_stimulus("sra_imm", exec_pkg::OP_ALU, 1'b1, '0, 32'd4,
                 5'd12, 5'd0, 5'd13, 32'h8000_0000, '0);
    tbl[n].alu_op = exec_pkg::SRA;
    set_expected(32'hf800_0000, 1'b1, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b0, '0);
    set_stimulus("and", exec_pkg::OP_ALU, 1'b0, '0, '0,
                 5'd14, 5'd15, 5'd16, 32'hf0f0_1234, 32'h0ff0_ff00);
    tbl[n].alu_op = exec_pkg::AND;
    set_expected(32'h00f0_1200, 1'b1, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b0, '0);
    set_stimulus("lui", exec_pkg::OP_LUI, 1'b1, '0, 32'h1234_5000, 5'd0, 5'd0, 5'd17, '0, '0);
    set_expected(32'h1234_5000, 1'b1, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b0, '0);
    set_stimulus("auipc", exec_pkg::OP_AUIPC, 1'b1, 32'h1000, 32'h2000,
                 5'd0, 5'd0, 5'd18, '0, '0);
    set_expected(32'h3000, 1'b1, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b0, '0);
    // Stale register data below must lose against the bypass.
    set_stimulus("fwd_imm", exec_pkg::OP_ALU, 1'b1, '0, 32'h10,
                 5'd18, 5'd0, 5'd19, 32'hdead_beef, '0);
    set_expected(32'h3010, 1'b1, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b0, '0);
    set_stimulus("fwd_to_x0", exec_pkg::OP_ALU, 1'b0, '0, '0, 5'd19, 5'd19, 5'd0, 32'd1, 32'd1);
    set_expected(32'h6020, 1'b1, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b0, '0);
    set_stimulus("no_fwd_x0", exec_pkg::OP_ALU, 1'b0, '0, '0, 5'd0, 5'd0, 5'd20, 32'd7, 32'd8);
    set_expected(32'd15, 1'b1, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b0, '0);
    set_stimulus("beq_taken", exec_pkg::OP_BRANCH, 1'b0, 32'h2000, 32'h40,
                 5'd21, 5'd22, 5'd0, 32'd5, 32'd5);
    set_expected('0, 1'b0, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b1, 32'h2040);
    set_stimulus("beq_not_taken", exec_pkg::OP_BRANCH, 1'b0, 32'h2080, 32'h40,
                 5'd21, 5'd22, 5'd0, 32'd5, 32'd6);
    set_expected('0, 1'b0, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b0, '0);
    set_stimulus("bltu", exec_pkg::OP_BRANCH, 1'b0, 32'h2100, 32'hffff_fff8,
                 5'd21, 5'd22, 5'd0, 32'd1, 32'hffff_ffff);
    tbl[n].branch_op = exec_pkg::BLTU; // Backward branch.
    set_expected('0, 1'b0, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b1, 32'h20f8);
    set_stimulus("jal", exec_pkg::OP_JAL, 1'b1, 32'h3000, 32'h100, 5'd0, 5'd0, 5'd1, '0, '0);
    set_expected(32'h3004, 1'b1, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b1, 32'h3100);
    set_stimulus("jalr", exec_pkg::OP_JALR, 1'b1, 32'h3100, 32'h10,
                 5'd23, 5'd0, 5'd2, 32'h4001, '0);
    set_expected(32'h3104, 1'b1, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b1, 32'h4010);
    set_stimulus("sb_off2", exec_pkg::OP_STORE, 1'b1, '0, 32'd2,
                 5'd24, 5'd25, 5'd0, 32'h8000, 32'hab);
    tbl[n].lsu_op = exec_pkg::SB;
    set_expected('0, 1'b0, 32'h8002, 4'b0100, 1'b0, exec_pkg::EC_NONE, 1'b0, '0);
    set_stimulus("sh_off2", exec_pkg::OP_STORE, 1'b1, '0, 32'd2,
                 5'd24, 5'd25, 5'd0, 32'h8000, 32'hab);
    tbl[n].lsu_op = exec_pkg::SH;
    set_expected('0, 1'b0, 32'h8002, 4'b1100, 1'b0, exec_pkg::EC_NONE, 1'b0, '0);
    set_stimulus("lw_misaligned", exec_pkg::OP_LOAD, 1'b1, '0, 32'd2,
                 5'd24, 5'd0, 5'd26, 32'h8000, '0);
    set_expected('0, 1'b0, 32'h8002, 4'b0000, 1'b1, exec_pkg::EC_LOAD_MISALIGNED, 1'b0, '0);
    set_stimulus("div_neg", exec_pkg::OP_DIV, 1'b0, '0, '0,
                 5'd27, 5'd28, 5'd29, 32'hffff_fff9, 32'd2);
    set_expected(32'hffff_fffd, 1'b1, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b0, '0);
    set_stimulus("remu", exec_pkg::OP_DIV, 1'b0, '0, '0,
                 5'd27, 5'd28, 5'd30, 32'hffff_fff9, 32'd10);
    tbl[n].div_op = exec_pkg::REMU;
    set_expected(32'd9, 1'b1, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b0, '0);
    set_stimulus("div_zero", exec_pkg::OP_DIV, 1'b0, '0, '0,
                 5'd27, 5'd28, 5'd31, 32'd1234, 32'd0);
    set_expected(32'hffff_ffff, 1'b1, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b0, '0);
    set_stimulus("mem_stall_hold", exec_pkg::OP_ALU, 1'b0, '0, '0,
                 5'd3, 5'd4, 5'd5, 32'd40, 32'd2);
    tbl[n].mem_stall = 1'b1;
    set_expected(32'd42, 1'b1, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b0, '0);
    set_stimulus("clear", exec_pkg::OP_ALU, 1'b0, '0, '0, 5'd1, 5'd2, 5'd6, 32'd1, 32'd1);
    tbl[n].clear = 1'b1;
    set_expected('0, 1'b0, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b0, '0);
    set_stimulus("after_clear", exec_pkg::OP_ALU, 1'b1, '0, 32'd5,
                 5'd6, 5'd0, 5'd7, 32'd10, '0);
    set_expected(32'd15, 1'b1, '0, 4'b0000, 1'b0, exec_pkg::EC_NONE, 1'b0, '0);
  endtask

  task automatic load_entry(input int i);
    valid <= 1'b1;
    op <= tbl[i].op;
    alu_op <= tbl[i].alu_op;
    branch_op <= tbl[i].branch_op;
    lsu_op <= tbl[i].lsu_op;
    div_op <= tbl[i].div_op;
    use_imm <= tbl[i].use_imm;
    pc <= tbl[i].pc;
    imm <= tbl[i].imm;
    raddr1 <= tbl[i].raddr1;
    raddr2 <= tbl[i].raddr2;
    waddr <= tbl[i].waddr;
    rdata1 <= tbl[i].rdata1;
    rdata2 <= tbl[i].rdata2;
    mem_stall <= tbl[i].mem_stall;
    clear <= tbl[i].clear;
    stall_cycles = '0;
  endtask

  task automatic check_entry(input int i);
    entry_t e;
    logic [`XLEN-1:0] exp_stall;
    logic is_mem;
    e = tbl[i];
    // A divide holds decode from presentation until its ready cycle.
    exp_stall = (e.op == exec_pkg::OP_DIV) ? `XLEN'(`DIV_STEPS + 1) : '0;
    is_mem = (e.op == exec_pkg::OP_LOAD) || (e.op == exec_pkg::OP_STORE);
    check_bit(names[i], "out_valid", !e.clear, out_valid);
    check_bit(names[i], "out_wren", e.exp_wren, out_wren);
    check_bit(names[i], "exception", e.exp_exc, exception);
    check_cause(names[i], "ecause", e.exp_cause, ecause);
    check_bit(names[i], "redirect", e.exp_redirect, redirect);
    check_data(names[i], "stall cycles", exp_stall, stall_seen[i]);
    if (!e.clear) begin
      check_op(names[i], "out_op", e.op, out_op);
      check_waddr(names[i], "out_waddr", e.waddr, out_waddr);
    end
    if (e.exp_wren) check_data(names[i], "out_wdata", e.exp_wdata, out_wdata);
    if (e.exp_redirect) check_data(names[i], "redirect_pc", e.exp_rpc, redirect_pc);
    if (is_mem && !e.clear) begin
      check_data(names[i], "out_address", e.exp_address, out_address);
      if (!e.exp_exc) check_be(names[i], "out_byteenable", e.exp_be, out_byteenable);
      if (e.op == exec_pkg::OP_STORE) begin
        check_data(names[i], "out_sdata", e.rdata2, out_sdata);
      end
    end
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b0;
    valid = 1'b0;
    op = exec_pkg::OP_NOP;
    alu_op = exec_pkg::ADD;
    branch_op = exec_pkg::BEQ;
    lsu_op = exec_pkg::LW;
    div_op = exec_pkg::DIV;
    use_imm = 1'b0;
    pc = '0;
    imm = '0;
    raddr1 = '0;
    raddr2 = '0;
    waddr = '0;
    rdata1 = '0;
    rdata2 = '0;
    mem_stall = 1'b0;
    clear = 1'b0;
    stall_cycles = '0;
    pending = 1'b0;
    go = 1'b0;
    cur = 0;
    prev = 0;
    held = 0;
    build_table();

    repeat (4) @(posedge clock);
    @(negedge clock);
    check_bit("reset", "out_valid", 1'b0, out_valid);
    check_bit("reset", "out_wren", 1'b0, out_wren);
    check_bit("reset", "exception", 1'b0, exception);
    check_bit("reset", "redirect", 1'b0, redirect);
    check_bit("reset", "stall", 1'b0, stall);
    @(posedge clock);
    reset <= 1'b1;
    load_entry(0);

    while (cur < NUM) begin
      @(negedge clock);
      if (pending || mem_stall) check_entry(prev); // Held output repeats the last result.
      pending = 1'b0;
      if (mem_stall) held = held + 1;
      if (stall) stall_cycles = stall_cycles + `XLEN'(1);
      go = !stall && !mem_stall;
      @(posedge clock);
      if (go) begin
        stall_seen[cur] = stall_cycles;
        prev = cur;
        pending = 1'b1;
        cur = cur + 1;
        if (cur < NUM) begin
          load_entry(cur);
        end else begin
          valid <= 1'b0;
          clear <= 1'b0;
        end
      end else if (held == 3) begin
        mem_stall <= 1'b0;
        held = 0;
      end
    end

    @(negedge clock);
    check_entry(prev);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+source
source/exec_pkg.sv
source/exec_ifs.sv
source/alu.sv
source/agu.sv
source/divider.sv
source/execute_stage.sv
source/execute_top.sv
tests/execute_tb.sv
